/* mips.f */
verilog/mips_pkg.sv
verilog/fetch.sv
verilog/control.sv
verilog/hazard.sv
verilog/decode.sv
verilog/execute.sv
verilog/memory.sv
verilog/mips.sv
verif/mips_checker.sv
verif/mips_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -f mips.f --top-module mips_tb -o mips_sim

result=$(./obj_dir/mips_sim)
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx "Done: no errors"; then
  exit 0
fi
exit 1

/* verif/mips_checker.sv */
`timescale 1ns/10ps
module mips_checker (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_valid,
  input  logic [4:0]  i_wb_addr,
  input  logic [31:0] i_wb_data,
  input  logic        i_exp_push,
  input  logic [4:0]  i_exp_rd,
  input  logic [31:0] i_exp_data,
  output logic        o_done,
  output int          o_mismatches,
  output int          o_unexpected,
  output int          o_missing
);
  localparam int SETTLE_CYCLES = 16;  // quiet stretch means jump-to-self reached

  logic [4:0]  exp_rd [$];
  logic [31:0] exp_data [$];
  int          next_idx   = 0;
  int          idle       = 0;
  int          k          = 0;
  int          mismatches = 0;
  int          unexpected = 0;
  int          missing    = 0;
  logic        done       = 1'b0;

  assign o_done       = done;
  assign o_mismatches = mismatches;
  assign o_unexpected = unexpected;
  assign o_missing    = missing;

  always @(posedge i_clk) begin
    if (i_exp_push) begin
      exp_rd.push_back(i_exp_rd);
      exp_data.push_back(i_exp_data);
    end
  end

  // writeback stream sampled mid-cycle
  always @(negedge i_clk) begin
    if (!i_rst_n) begin
      if (i_wb_valid) begin
        $display("%0t: writeback to r%0d while the core is in reset", $time, i_wb_addr);
        unexpected++;
      end
    end else if (!done) begin
      if (i_wb_valid) begin
        idle = 0;
        if (next_idx >= exp_rd.size()) begin
          $display("%0t: unexpected write r%0d = %h", $time, i_wb_addr, i_wb_data);
          unexpected++;
        end else begin
          if (i_wb_addr !== exp_rd[next_idx] || i_wb_data !== exp_data[next_idx]) begin
            $display("MISMATCH at %0t: r%0d = %h, expected r%0d = %h", $time, i_wb_addr,
                     i_wb_data, exp_rd[next_idx], exp_data[next_idx]);
            mismatches++;
          end
          next_idx++;
        end
      end else begin
        idle++;
        if (idle == SETTLE_CYCLES) begin
          for (k = next_idx; k < exp_rd.size(); k++) begin
            $display("missing write: r%0d = %h never retired", exp_rd[k], exp_data[k]);
          end
          missing = exp_rd.size() - next_idx;
          done    = 1'b1;
        end
      end
    end
  end

endmodule

/* verif/mips_tb.sv */
`timescale 1ns/10ps
module mips_tb;
  import mips_pkg::*;

  localparam int IAW         = $clog2(IMEM_WORDS);
  localparam int HALF_PERIOD = 50;

  logic            i_clk = 1'b0;
  logic            i_rst_n;
  logic            i_imem_we;
  logic [IAW-1:0]  i_imem_addr;
  logic [XLEN-1:0] i_imem_data;
  logic            wb_valid;
  logic [4:0]      wb_addr;
  logic [XLEN-1:0] wb_data;
  logic            exp_push;
  logic [4:0]      exp_rd;
  logic [XLEN-1:0] exp_data;
  logic            chk_done;
  int              mismatches;
  int              unexpected;
  int              missing;
  int              n_words;
  int              fd;
  logic            load_done;

  mips u_dut (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr),
    .i_imem_data(i_imem_data), .o_wb_valid(wb_valid), .o_wb_addr(wb_addr), .o_wb_data(wb_data)
  );

  mips_checker u_checker (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wb_valid(wb_valid), .i_wb_addr(wb_addr),
    .i_wb_data(wb_data), .i_exp_push(exp_push), .i_exp_rd(exp_rd), .i_exp_data(exp_data),
    .o_done(chk_done), .o_mismatches(mismatches), .o_unexpected(unexpected),
    .o_missing(missing)
  );

  always #HALF_PERIOD i_clk = ~i_clk;

  // each P or W line takes one falling edge
  task automatic read_tests(input int fh);
    string       line;
    int          code;
    logic [31:0] a;
    logic [31:0] b;
    while (!$feof(fh)) begin
      code = $fgets(line, fh);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        @(negedge i_clk);
        i_imem_we = 1'b0;
        exp_push  = 1'b0;
        if (line[0] == "P") begin
          code        = $sscanf(line.substr(1, line.len() - 1), "%h", a);
          i_imem_we   = 1'b1;
          i_imem_addr = IAW'(n_words);
          i_imem_data = a;
          n_words++;
        end else if (line[0] == "W") begin
          code     = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
          exp_push = 1'b1;
          exp_rd   = a[4:0];
          exp_data = b;
        end
      end
    end
  endtask

  initial begin
    i_rst_n     = 1'b0;
    i_imem_we   = 1'b0;
    i_imem_addr = '0;
    i_imem_data = '0;
    exp_push    = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    n_words     = 0;
    load_done   = 1'b0;
    fd = $fopen("verif/mips_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file verif/mips_tests.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      read_tests(fd);
      $fclose(fd);
      @(negedge i_clk);
      i_imem_we = 1'b0;
      exp_push  = 1'b0;
      repeat (3) @(negedge i_clk);  // 3 more reset cycles once loaded
      i_rst_n   = 1'b1;
      load_done = 1'b1;
      wait (chk_done);
      $display("errors: %0d mismatched, %0d unexpected, %0d missing",
               mismatches, unexpected, missing);
      if (mismatches + unexpected + missing == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

  // watchdog scaled by program length
  initial begin
    wait (load_done);
    repeat (20 * n_words + 100) @(posedge i_clk);
    $display("timeout: the program did not settle within %0d cycles", 20 * n_words + 100);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* verif/mips_tests.txt */
# P <word>: program word in hex, loaded from address 0 up
# W <reg> <value>: expected register write in hex, in retire order
P 20010005  # 00 addi r1, r0, 5
P 2002fffd  # 04 addi r2, r0, -3
P 00221820  # 08 add r3, r1, r2
P 00412022  # 0c sub r4, r2, r1
P 0041282a  # 10 slt r5, r2, r1
P 00413024  # 14 and r6, r2, r1
P 00813825  # 18 or r7, r4, r1
P 3048f0f0  # 1c andi r8, r2, 0xf0f0
P 34098001  # 20 ori r9, r0, 0x8001
P ac070008  # 24 sw r7, 8(r0)
P 8c0a0008  # 28 lw r10, 8(r0)
P 01415820  # 2c add r11, r10, r1 (load-use)
P 20200007  # 30 addi r0, r1, 7
P 00016020  # 34 add r12, r0, r1
P 106b0001  # 38 beq r3, r11, 0x40 (taken)
P 200d0063  # 3c addi r13, r0, 99 (flushed)
P 14210001  # 40 bne r1, r1, 0x48 (not taken)
P 200e0077  # 44 addi r14, r0, 0x77
P 08000014  # 48 j 0x50
P 200f0001  # 4c addi r15, r0, 1 (flushed)
P 21d00001  # 50 addi r16, r14, 1
P 08000015  # 54 j 0x54
W 01 00000005
W 02 fffffffd
W 03 00000002
W 04 fffffff8
W 05 00000001
W 06 00000005
W 07 fffffffd
W 08 0000f0f0
W 09 00008001
W 0a fffffffd
W 0b 00000002
W 0c 00000005
W 0e 00000077
W 10 00000078

/* verilog/control.sv */
`timescale 1ns/10ps
module control (
  input  logic [5:0]      i_opcode,
  input  logic [5:0]      i_funct,
  input  logic            i_bubble,
  output mips_pkg::ctrl_t o_ctrl
);
  import mips_pkg::*;

  always_comb begin
    o_ctrl = '0;
    if (!i_bubble) begin
      case (i_opcode)
        OP_RTYPE: begin
          o_ctrl.reg_dst   = 1'b1;
          o_ctrl.reg_write = 1'b1;
          case (i_funct)
            FN_ADD:  o_ctrl.alu_op = ALU_ADD;
            FN_SUB:  o_ctrl.alu_op = ALU_SUB;
            FN_AND:  o_ctrl.alu_op = ALU_AND;
            FN_OR:   o_ctrl.alu_op = ALU_OR;
            FN_SLT:  o_ctrl.alu_op = ALU_SLT;
            default: o_ctrl = '0;  // shifts etc. become no-ops
          endcase
        end
        OP_ADDI: o_ctrl = '{reg_write: 1'b1, alu_src_imm: 1'b1, ext_signed: 1'b1,
                            alu_op: ALU_ADD, default: '0};
        OP_ANDI: o_ctrl = '{reg_write: 1'b1, alu_src_imm: 1'b1, alu_op: ALU_AND, default: '0};
        OP_ORI:  o_ctrl = '{reg_write: 1'b1, alu_src_imm: 1'b1, alu_op: ALU_OR, default: '0};
        OP_LW:   o_ctrl = '{reg_write: 1'b1, mem_read: 1'b1, mem_to_reg: 1'b1, alu_src_imm: 1'b1,
                            ext_signed: 1'b1, alu_op: ALU_ADD, default: '0};
        OP_SW:   o_ctrl = '{mem_write: 1'b1, alu_src_imm: 1'b1, ext_signed: 1'b1,
                            alu_op: ALU_ADD, default: '0};
        OP_BEQ:  o_ctrl = '{beq: 1'b1, ext_signed: 1'b1, alu_op: ALU_ADD, default: '0};
        OP_BNE:  o_ctrl = '{bne: 1'b1, ext_signed: 1'b1, alu_op: ALU_ADD, default: '0};
        OP_J:    o_ctrl = '{jump: 1'b1, alu_op: ALU_ADD, default: '0};
        default: o_ctrl = '0;
      endcase
    end
  end

endmodule

/* verilog/decode.sv */
`timescale 1ns/10ps
module decode (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  mips_pkg::instr_u          i_instr,
  input  logic [mips_pkg::XLEN-1:0] i_pc_plus4,
  input  mips_pkg::ctrl_t           i_ctrl,
  input  mips_pkg::fwd_e            i_fwd_a,
  input  mips_pkg::fwd_e            i_fwd_b,
  input  logic                      i_stall,
  input  logic [mips_pkg::XLEN-1:0] i_ex_result,
  input  logic [mips_pkg::XLEN-1:0] i_mem_result,
  input  mips_pkg::memwb_t          i_wb,
  output logic [mips_pkg::XLEN-1:0] o_next_pc,
  output logic                      o_taken,
  output mips_pkg::idex_t           o_idex
);
  import mips_pkg::*;

  logic [XLEN-1:0] regs [32];
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] br_off;
  logic [4:0]      dest;
  logic            equal;
  ctrl_t           ctrl_q;

  always_ff @(posedge i_clk) begin
    if (i_wb.reg_write && i_wb.rd != 5'd0) begin
      regs[i_wb.rd] <= i_wb.wdata;
    end
  end

  // write-first read with r0 hardwired
  function automatic logic [XLEN-1:0] rf_read(input logic [4:0] r);
    if (r == 5'd0) return '0;
    if (i_wb.reg_write && i_wb.rd == r) return i_wb.wdata;
    return regs[r];
  endfunction

  function automatic logic [XLEN-1:0] pick(input fwd_e sel, input logic [4:0] r);
    case (sel)
      FWD_EX:  return i_ex_result;
      FWD_MEM: return i_mem_result;
      default: return rf_read(r);
    endcase
  endfunction

  always_comb begin
    op_a = pick(i_fwd_a, i_instr.r_fmt.rs);
    op_b = pick(i_fwd_b, i_instr.r_fmt.rt);
  end

  assign equal  = (op_a == op_b);
  assign br_off = {{14{i_instr.i_fmt.imm16[15]}}, i_instr.i_fmt.imm16, 2'b00};

  assign o_next_pc = i_ctrl.jump
                   ? {i_pc_plus4[31:28], i_instr.i_fmt.rs, i_instr.i_fmt.rt,
                      i_instr.i_fmt.imm16, 2'b00}
                   : i_pc_plus4 + br_off;
  assign o_taken = !i_stall &&
                   (i_ctrl.jump || (i_ctrl.beq && equal) || (i_ctrl.bne && !equal));

  assign dest = i_ctrl.reg_dst ? i_instr.r_fmt.rd : i_instr.r_fmt.rt;

  always_comb begin
    ctrl_q           = i_ctrl;
    ctrl_q.reg_write = i_ctrl.reg_write && (dest != 5'd0);  // r0 writes dropped here
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_idex <= '0;
    end else begin
      o_idex.ctrl  <= ctrl_q;
      o_idex.op_a  <= op_a;
      o_idex.op_b  <= op_b;
      o_idex.imm16 <= i_instr.i_fmt.imm16;
      o_idex.rd    <= dest;
    end
  end

endmodule

/* verilog/execute.sv */
`timescale 1ns/10ps
module execute (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  mips_pkg::idex_t           i_idex,
  output logic [mips_pkg::XLEN-1:0] o_result,
  output mips_pkg::exmem_t          o_exmem
);
  import mips_pkg::*;

  logic [XLEN-1:0] imm_ext;
  logic [XLEN-1:0] alu_b;

  assign imm_ext = i_idex.ctrl.ext_signed ? {{16{i_idex.imm16[15]}}, i_idex.imm16}
                                          : {16'h0000, i_idex.imm16};
  assign alu_b   = i_idex.ctrl.alu_src_imm ? imm_ext : i_idex.op_b;

  always_comb begin
    case (i_idex.ctrl.alu_op)
      ALU_SUB: o_result = i_idex.op_a - alu_b;
      ALU_AND: o_result = i_idex.op_a & alu_b;
      ALU_OR:  o_result = i_idex.op_a | alu_b;
      ALU_SLT: o_result = {31'd0, $signed(i_idex.op_a) < $signed(alu_b)};
      default: o_result = i_idex.op_a + alu_b;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_exmem <= '0;
    end else begin
      o_exmem.reg_write  <= i_idex.ctrl.reg_write;
      o_exmem.mem_read   <= i_idex.ctrl.mem_to_reg;  // selects load data downstream
      o_exmem.mem_write  <= i_idex.ctrl.mem_write;
      o_exmem.alu        <= o_result;
      o_exmem.store_data <= i_idex.op_b;
      o_exmem.rd         <= i_idex.rd;
    end
  end

endmodule

/* verilog/fetch.sv */
`timescale 1ns/10ps
module fetch (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_imem_we,
  input  logic [$clog2(mips_pkg::IMEM_WORDS)-1:0] i_imem_addr,
  input  logic [mips_pkg::XLEN-1:0]             i_imem_data,
  input  logic [mips_pkg::XLEN-1:0]             i_next_pc,
  input  logic                                  i_taken,
  input  logic                                  i_stall,
  output mips_pkg::instr_u                      o_instr,
  output logic [mips_pkg::XLEN-1:0]             o_pc_plus4
);
  import mips_pkg::*;

  localparam int IAW = $clog2(IMEM_WORDS);

  logic [XLEN-1:0] imem [IMEM_WORDS];
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] pc_plus4;

  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n && i_imem_we) begin  // program load only in reset
      imem[i_imem_addr] <= i_imem_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pc         <= '0;
      o_instr    <= '0;
      o_pc_plus4 <= '0;
    end else if (i_taken) begin
      pc         <= i_next_pc;
      o_instr    <= '0;  // squash the wrong-path word
      o_pc_plus4 <= '0;
    end else if (!i_stall) begin
      pc         <= pc_plus4;
      o_instr    <= imem[pc[IAW+1:2]];
      o_pc_plus4 <= pc_plus4;
    end
  end

endmodule

/* verilog/hazard.sv */
`timescale 1ns/10ps
module hazard (
  input  logic [4:0]     i_rs,
  input  logic [4:0]     i_rt,
  input  logic [4:0]     i_ex_rd,
  input  logic           i_ex_reg_write,
  input  logic           i_ex_mem_read,
  input  logic [4:0]     i_mem_rd,
  input  logic           i_mem_reg_write,
  output mips_pkg::fwd_e o_fwd_a,
  output mips_pkg::fwd_e o_fwd_b,
  output logic           o_stall
);
  import mips_pkg::*;

  // youngest producer wins
  function automatic fwd_e fwd_sel(input logic [4:0] r);
    if (r == 5'd0) return FWD_NONE;
    if (i_ex_reg_write && i_ex_rd == r) return FWD_EX;
    if (i_mem_reg_write && i_mem_rd == r) return FWD_MEM;
    return FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_a = fwd_sel(i_rs);
    o_fwd_b = fwd_sel(i_rt);
  end

  // load data not ready until memory stage
  assign o_stall = i_ex_mem_read && (i_ex_rd != 5'd0) &&
                   ((i_ex_rd == i_rs) || (i_ex_rd == i_rt));

endmodule

/* verilog/memory.sv */
`timescale 1ns/10ps
module memory (
  input  logic                      i_clk,
  input  logic                      i_rst_n,
  input  mips_pkg::exmem_t          i_exmem,
  output logic [mips_pkg::XLEN-1:0] o_result,
  output mips_pkg::memwb_t          o_memwb
);
  import mips_pkg::*;

  localparam int DAW = $clog2(DMEM_WORDS);

  logic [XLEN-1:0] dmem [DMEM_WORDS];
  logic [DAW-1:0]  idx;

  assign idx      = i_exmem.alu[DAW+1:2];  // word addressed
  assign o_result = i_exmem.mem_read ? dmem[idx] : i_exmem.alu;

  always_ff @(posedge i_clk) begin
    if (i_exmem.mem_write) dmem[idx] <= i_exmem.store_data;
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_memwb <= '0;
    end else begin
      o_memwb.reg_write <= i_exmem.reg_write;
      o_memwb.wdata     <= o_result;
      o_memwb.rd        <= i_exmem.rd;
    end
  end

endmodule

/* verilog/mips.sv */
`timescale 1ns/10ps
module mips (
  input  logic                                  i_clk,
  input  logic                                  i_rst_n,
  input  logic                                  i_imem_we,
  input  logic [$clog2(mips_pkg::IMEM_WORDS)-1:0] i_imem_addr,
  input  logic [mips_pkg::XLEN-1:0]             i_imem_data,
  output logic                                  o_wb_valid,
  output logic [4:0]                            o_wb_addr,
  output logic [mips_pkg::XLEN-1:0]             o_wb_data
);
  import mips_pkg::*;

  instr_u          instr;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] next_pc;
  logic            taken;
  logic            stall;
  ctrl_t           ctrl;
  fwd_e            fwd_a;
  fwd_e            fwd_b;
  idex_t           idex;
  exmem_t          exmem;
  memwb_t          memwb;
  logic [XLEN-1:0] ex_result;
  logic [XLEN-1:0] mem_result;

  fetch u_fetch (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_imem_we(i_imem_we), .i_imem_addr(i_imem_addr),
    .i_imem_data(i_imem_data), .i_next_pc(next_pc), .i_taken(taken), .i_stall(stall),
    .o_instr(instr), .o_pc_plus4(pc_plus4)
  );

  control u_control (
    .i_opcode(instr.r_fmt.opcode), .i_funct(instr.r_fmt.funct), .i_bubble(stall),
    .o_ctrl(ctrl)
  );

  hazard u_hazard (
    .i_rs(instr.r_fmt.rs), .i_rt(instr.r_fmt.rt), .i_ex_rd(idex.rd),
    .i_ex_reg_write(idex.ctrl.reg_write), .i_ex_mem_read(idex.ctrl.mem_read),
    .i_mem_rd(exmem.rd), .i_mem_reg_write(exmem.reg_write),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall(stall)
  );

  decode u_decode (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_instr(instr), .i_pc_plus4(pc_plus4),
    .i_ctrl(ctrl), .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_stall(stall),
    .i_ex_result(ex_result), .i_mem_result(mem_result), .i_wb(memwb),
    .o_next_pc(next_pc), .o_taken(taken), .o_idex(idex)
  );

  execute u_execute (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_idex(idex), .o_result(ex_result), .o_exmem(exmem)
  );

  memory u_memory (
    .i_clk(i_clk), .i_rst_n(i_rst_n), .i_exmem(exmem), .o_result(mem_result), .o_memwb(memwb)
  );

  assign o_wb_valid = memwb.reg_write;  // never set for r0
  assign o_wb_addr  = memwb.rd;
  assign o_wb_data  = memwb.wdata;

endmodule

/* verilog/mips_pkg.sv */
package mips_pkg;

  localparam int XLEN       = 32;
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'h00,
    OP_J     = 6'h02,
    OP_BEQ   = 6'h04,
    OP_BNE   = 6'h05,
    OP_ADDI  = 6'h08,
    OP_ANDI  = 6'h0c,
    OP_ORI   = 6'h0d,
    OP_LW    = 6'h23,
    OP_SW    = 6'h2b
  } opcode_e;

  typedef enum logic [5:0] {
    FN_ADD = 6'h20,
    FN_SUB = 6'h22,
    FN_AND = 6'h24,
    FN_OR  = 6'h25,
    FN_SLT = 6'h2a
  } funct_e;

  typedef union packed {
    struct packed {
      logic [5:0] opcode;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
    } r_fmt;
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
    } i_fmt;  // low 26 bits double as jump target
  } instr_u;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_SLT = 3'd4
  } alu_op_e;

  typedef struct packed {
    logic    reg_dst;
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    mem_to_reg;
    logic    alu_src_imm;
    logic    ext_signed;
    alu_op_e alu_op;
    logic    beq;
    logic    bne;
    logic    jump;
  } ctrl_t;

  typedef struct packed {
    ctrl_t            ctrl;
    logic [XLEN-1:0]  op_a;
    logic [XLEN-1:0]  op_b;
    logic [15:0]      imm16;
    logic [4:0]       rd;
  } idex_t;

  typedef struct packed {
    logic            reg_write;
    logic            mem_read;
    logic            mem_write;
    logic [XLEN-1:0] alu;
    logic [XLEN-1:0] store_data;
    logic [4:0]      rd;
  } exmem_t;

  typedef struct packed {
    logic            reg_write;
    logic [XLEN-1:0] wdata;
    logic [4:0]      rd;
  } memwb_t;

  typedef enum logic [1:0] {
    FWD_NONE = 2'd0,
    FWD_EX   = 2'd1,
    FWD_MEM  = 2'd2
  } fwd_e;

endpackage
